// File: src/aluPkg.sv
// ALU data width, opcode groups, funct and shift codes, control word struct
package aluPkg;

    localparam int dataWidth = 16;               // Operand and result width

    // Opcode groups, opcode bits 4..2
    localparam logic [2:0] opNop      = 3'b000;
    localparam logic [2:0] opJump     = 3'b001;  // Other pipeline stage
    localparam logic [2:0] opArithImm = 3'b010;
    localparam logic [2:0] opBranch   = 3'b011;  // Other pipeline stage
    localparam logic [2:0] opMem      = 3'b100;  // Other pipeline stage
    localparam logic [2:0] opShiftImm = 3'b101;
    localparam logic [2:0] opRegOp    = 3'b110;
    localparam logic [2:0] opCond     = 3'b111;

    // Sub-selects inside opRegOp, opcode bits 1..0
    localparam logic [1:0] subRegShift = 2'b10;
    localparam logic [1:0] subRegArith = 2'b11;

    // Arithmetic funct codes
    localparam logic [1:0] fnAdd  = 2'b00;
    localparam logic [1:0] fnSub  = 2'b01;
    localparam logic [1:0] fnXor  = 2'b10;
    localparam logic [1:0] fnNand = 2'b11;

    // Same positions select the shift kind
    localparam logic [1:0] fnSll = 2'b00;
    localparam logic [1:0] fnSrl = 2'b01;
    localparam logic [1:0] fnRol = 2'b10;
    localparam logic [1:0] fnRor = 2'b11;

    typedef struct packed {
        logic [4:0] opcode;                      // Group in 4..2, select in 1..0
        logic [1:0] funct;                       // Register op select
    } aluCtrl;

    typedef enum logic [1:0] {
        shiftSll = fnSll,
        shiftSrl = fnSrl,
        shiftRol = fnRol,
        shiftRor = fnRor
    } shiftKind;

endpackage

// File: src/axiLitePkg.sv
// AXI4-Lite request and response structs, response codes, register map offsets
package axiLitePkg;

    localparam int addrWidth = 5;

    // Register map
    localparam logic [addrWidth-1:0] regA      = 5'h00;
    localparam logic [addrWidth-1:0] regB      = 5'h04;
    localparam logic [addrWidth-1:0] regCtrl   = 5'h08;
    localparam logic [addrWidth-1:0] regResult = 5'h0C;  // Read only
    localparam logic [addrWidth-1:0] regStatus = 5'h10;  // Carry in bit 0

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // Master to slave
    typedef struct packed {
        logic                 awvalid;
        logic [addrWidth-1:0] awaddr;
        logic                 wvalid;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;
        logic                 bready;
        logic                 arvalid;
        logic [addrWidth-1:0] araddr;
        logic                 rready;
    } axiLiteReq;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiLiteRsp;

endpackage

// File: src/claAdder.sv
// 16-bit two-level carry-lookahead adder built from four 4-bit groups
`timescale 1ns/10ps

module claAdder (
    input  logic [aluPkg::dataWidth-1:0] a,
    input  logic [aluPkg::dataWidth-1:0] b,
    input  logic                         cIn,
    output logic [aluPkg::dataWidth-1:0] sum,
    output logic                         cOut
);

    logic [aluPkg::dataWidth-1:0] p;             // Bit propagate
    logic [aluPkg::dataWidth-1:0] g;             // Bit generate
    logic [aluPkg::dataWidth-1:0] c;             // Carry into each bit
    logic [3:0]                   gp;            // Group propagate
    logic [3:0]                   gg;            // Group generate
    logic [4:0]                   gc;            // Carry into each group

    assign p = a ^ b;
    assign g = a & b;

    for (genvar i = 0; i < 4; i++) begin : groupGen
        logic [3:0] pl;
        logic [3:0] gl;

        assign pl = p[4*i +: 4];
        assign gl = g[4*i +: 4];

        assign gp[i] = &pl;
        assign gg[i] = gl[3] | (pl[3] & gl[2]) | (pl[3] & pl[2] & gl[1])
                     | (pl[3] & pl[2] & pl[1] & gl[0]);

        // Carries inside the group from the group carry-in
        assign c[4*i]     = gc[i];
        assign c[4*i + 1] = gl[0] | (pl[0] & gc[i]);
        assign c[4*i + 2] = gl[1] | (pl[1] & gl[0]) | (pl[1] & pl[0] & gc[i]);
        assign c[4*i + 3] = gl[2] | (pl[2] & gl[1]) | (pl[2] & pl[1] & gl[0])
                          | (pl[2] & pl[1] & pl[0] & gc[i]);
    end

    // Second lookahead level across the groups
    assign gc[0] = cIn;
    assign gc[1] = gg[0] | (gp[0] & cIn);
    assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & cIn);
    assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                 | (gp[2] & gp[1] & gp[0] & cIn);
    assign gc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                 | (gp[3] & gp[2] & gp[1] & gg[0])
                 | (gp[3] & gp[2] & gp[1] & gp[0] & cIn);

    assign sum  = p ^ c;
    assign cOut = gc[4];

endmodule

// File: src/barrelShifter.sv
// Four-stage logarithmic shifter for SLL, SRL, ROL and ROR
`timescale 1ns/10ps

module barrelShifter (
    input  logic [aluPkg::dataWidth-1:0] value,
    input  logic [3:0]                   amount,
    input  aluPkg::shiftKind             kind,
    output logic [aluPkg::dataWidth-1:0] shifted
);

    logic [aluPkg::dataWidth-1:0] s1;            // After shift by 1
    logic [aluPkg::dataWidth-1:0] s2;            // After shift by 2
    logic [aluPkg::dataWidth-1:0] s4;            // After shift by 4

    // One stage, moves by n when enabled; rotates wrap the bits that fall off
    function automatic logic [aluPkg::dataWidth-1:0] shiftStage(
        input logic [aluPkg::dataWidth-1:0] x,
        input logic                         en,
        input aluPkg::shiftKind             k,
        input int                           n
    );
        logic [aluPkg::dataWidth-1:0] r;
        case (k)
            aluPkg::shiftSll: r = x << n;                                  // Zero fill
            aluPkg::shiftSrl: r = x >> n;                                  // Zero fill
            aluPkg::shiftRol: r = (x << n) | (x >> (aluPkg::dataWidth - n));
            aluPkg::shiftRor: r = (x >> n) | (x << (aluPkg::dataWidth - n));
            default:          r = x;
        endcase
        return en ? r : x;
    endfunction

    assign s1      = shiftStage(value, amount[0], kind, 1);
    assign s2      = shiftStage(s1, amount[1], kind, 2);
    assign s4      = shiftStage(s2, amount[2], kind, 4);
    assign shifted = shiftStage(s4, amount[3], kind, 8);

endmodule

// File: src/alu.sv
// ALU decode, add and subtract, logic ops, shifts and conditional sets
`timescale 1ns/10ps

module alu (
    input  logic [aluPkg::dataWidth-1:0] operandA,
    input  logic [aluPkg::dataWidth-1:0] operandB,
    input  aluPkg::aluCtrl               ctrl,
    output logic [aluPkg::dataWidth-1:0] result,
    output logic                         carry
);

    localparam int msb = aluPkg::dataWidth - 1;

    logic [2:0]                   group;
    logic [1:0]                   sel;
    logic [1:0]                   op;            // Arith or shift select
    logic                         isRegArith;
    logic                         isRegShift;
    logic                         isArith;
    logic                         doSub;
    logic [aluPkg::dataWidth-1:0] addB;
    logic [aluPkg::dataWidth-1:0] sum;
    logic                         cOut;
    logic [aluPkg::dataWidth-1:0] shifted;
    logic [aluPkg::dataWidth-1:0] arithResult;
    logic                         equal;
    logic                         overflow;
    logic                         less;
    logic                         condBit;

    assign group      = ctrl.opcode[4:2];
    assign sel        = ctrl.opcode[1:0];
    assign isRegArith = (group == aluPkg::opRegOp) && (sel == aluPkg::subRegArith);
    assign isRegShift = (group == aluPkg::opRegOp) && (sel == aluPkg::subRegShift);
    assign isArith    = (group == aluPkg::opArithImm) || isRegArith;
    assign op         = (isRegArith || isRegShift) ? ctrl.funct : sel;

    // SLT and SLE reuse the adder as A minus B
    assign doSub = (isArith && op == aluPkg::fnSub)
                || (group == aluPkg::opCond && (sel == 2'b01 || sel == 2'b10));
    assign addB  = doSub ? ~operandB : operandB;

    claAdder i_claAdder (
        .a    (operandA),
        .b    (addB),
        .cIn  (doSub),                           // +1 completes two's complement
        .sum  (sum),
        .cOut (cOut)
    );

    barrelShifter i_barrelShifter (
        .value   (operandA),
        .amount  (operandB[3:0]),
        .kind    (aluPkg::shiftKind'(op)),
        .shifted (shifted)
    );

    assign equal    = (operandA == operandB);
    assign overflow = (operandA[msb] == addB[msb]) && (sum[msb] != operandA[msb]);
    assign less     = sum[msb] ^ overflow;       // Signed A < B

    always_comb begin
        case (op)
            aluPkg::fnXor:  arithResult = operandA ^ operandB;
            aluPkg::fnNand: arithResult = ~(operandA & operandB);
            default:        arithResult = sum;   // ADD and SUB
        endcase

        case (sel)
            2'b00:   condBit = equal;            // SEQ
            2'b01:   condBit = less;             // SLT
            2'b10:   condBit = less | equal;     // SLE
            default: condBit = cOut;             // SCO, carry of A plus B
        endcase
    end

    always_comb begin
        case (group)
            aluPkg::opArithImm: result = arithResult;
            aluPkg::opShiftImm: result = shifted;
            aluPkg::opRegOp:    result = isRegArith ? arithResult
                                       : isRegShift ? shifted : '0;
            aluPkg::opCond:     result = {{msb{1'b0}}, condBit};
            aluPkg::opNop, aluPkg::opJump, aluPkg::opBranch, aluPkg::opMem:
                                result = '0;     // Handled outside this unit
            default:            result = '0;
        endcase
    end

    assign carry = isArith && (op == aluPkg::fnAdd || op == aluPkg::fnSub) && cOut;

endmodule

// File: src/aluRegSlave.sv
// AXI4-Lite slave with operand and control registers, result and status readback
`timescale 1ns/10ps

module aluRegSlave (
    input  logic                         clk,
    input  logic                         reset,
    input  axiLitePkg::axiLiteReq        axiReq,
    output axiLitePkg::axiLiteRsp        axiRsp,
    output logic [aluPkg::dataWidth-1:0] operandA,
    output logic [aluPkg::dataWidth-1:0] operandB,
    output aluPkg::aluCtrl               ctrl,
    input  logic [aluPkg::dataWidth-1:0] result,
    input  logic                         carry
);

    logic [aluPkg::dataWidth-1:0] aReg;
    logic [aluPkg::dataWidth-1:0] bReg;
    aluPkg::aluCtrl               ctrlReg;
    logic                         bValid;
    logic [1:0]                   bResp;
    logic                         rValid;
    logic [31:0]                  rData;
    logic [1:0]                   rResp;
    logic                         wrAccept;
    logic                         rdAccept;
    logic [31:0]                  readData;
    logic [1:0]                   readResp;

    // Byte lanes 0 and 1 of a 16-bit register
    function automatic logic [aluPkg::dataWidth-1:0] mergeBytes(
        input logic [aluPkg::dataWidth-1:0] old,
        input logic [aluPkg::dataWidth-1:0] data,
        input logic [1:0]                   strb
    );
        logic [aluPkg::dataWidth-1:0] merged;
        merged = old;
        if (strb[0]) begin
            merged[7:0] = data[7:0];
        end
        if (strb[1]) begin
            merged[15:8] = data[15:8];
        end
        return merged;
    endfunction

    assign wrAccept = axiReq.awvalid && axiReq.wvalid && !bValid;  // AW and W together
    assign rdAccept = axiReq.arvalid && !rValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            aReg    <= '0;
            bReg    <= '0;
            ctrlReg <= '0;                       // NOP
            bValid  <= 1'b0;
        end else if (wrAccept) begin
            bValid <= 1'b1;
            bResp  <= axiLitePkg::respOkay;
            case (axiReq.awaddr)
                axiLitePkg::regA: aReg <= mergeBytes(aReg, axiReq.wdata[15:0], axiReq.wstrb[1:0]);
                axiLitePkg::regB: bReg <= mergeBytes(bReg, axiReq.wdata[15:0], axiReq.wstrb[1:0]);
                axiLitePkg::regCtrl: begin
                    if (axiReq.wstrb[0]) begin
                        ctrlReg <= aluPkg::aluCtrl'(axiReq.wdata[6:0]);
                    end
                end
                default: bResp <= axiLitePkg::respSlvErr;  // Unmapped or read only
            endcase
        end else if (bValid && axiReq.bready) begin
            bValid <= 1'b0;
        end
    end

    // Read data from the live registers and ALU output
    always_comb begin
        readResp = axiLitePkg::respOkay;
        case (axiReq.araddr)
            axiLitePkg::regA:      readData = 32'(aReg);
            axiLitePkg::regB:      readData = 32'(bReg);
            axiLitePkg::regCtrl:   readData = 32'(ctrlReg);
            axiLitePkg::regResult: readData = 32'(result);
            axiLitePkg::regStatus: readData = 32'(carry);
            default: begin
                readData = '0;
                readResp = axiLitePkg::respSlvErr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rValid <= 1'b0;
        end else if (rdAccept) begin
            rValid <= 1'b1;
            rData  <= readData;                  // Held until rready
            rResp  <= readResp;
        end else if (rValid && axiReq.rready) begin
            rValid <= 1'b0;
        end
    end

    assign axiRsp.awready = wrAccept;
    assign axiRsp.wready  = wrAccept;
    assign axiRsp.bvalid  = bValid;
    assign axiRsp.bresp   = bResp;
    assign axiRsp.arready = rdAccept;
    assign axiRsp.rvalid  = rValid;
    assign axiRsp.rdata   = rData;
    assign axiRsp.rresp   = rResp;

    assign operandA = aReg;
    assign operandB = bReg;
    assign ctrl     = ctrlReg;

endmodule

// File: src/aluCore.sv
// ALU coprocessor top with AXI4-Lite register slave and combinational ALU
`timescale 1ns/10ps

module aluCore (
    input  logic                  clk,
    input  logic                  reset,
    input  axiLitePkg::axiLiteReq axiReq,
    output axiLitePkg::axiLiteRsp axiRsp
);

    logic [aluPkg::dataWidth-1:0] operandA;
    logic [aluPkg::dataWidth-1:0] operandB;
    aluPkg::aluCtrl               ctrl;
    logic [aluPkg::dataWidth-1:0] result;
    logic                         carry;

    aluRegSlave i_aluRegSlave (
        .clk      (clk),
        .reset    (reset),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp),
        .operandA (operandA),
        .operandB (operandB),
        .ctrl     (ctrl),
        .result   (result),                      // Sampled on read accept
        .carry    (carry)
    );

    alu i_alu (
        .operandA (operandA),
        .operandB (operandB),
        .ctrl     (ctrl),
        .result   (result),
        .carry    (carry)
    );

endmodule

// File: sim/aluCore_props.sv
// AXI4-Lite handshake assertions bound into the ALU register slave
`timescale 1ns/10ps

module aluCore_props (
    input logic                  clk,
    input logic                  reset,
    input axiLitePkg::axiLiteReq axiReq,
    input axiLitePkg::axiLiteRsp axiRsp
);

    int failCount = 0;                           // Assertion failures so far

    bValidHold: assert property (@(posedge clk) disable iff (reset)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp))
        else begin
            failCount++;
            $error("bvalid dropped or bresp changed before bready");
        end

    // Read data frozen while the host stalls
    rValidHold: assert property (@(posedge clk) disable iff (reset)
        axiRsp.rvalid && !axiReq.rready |=>
            axiRsp.rvalid && $stable(axiRsp.rdata) && $stable(axiRsp.rresp))
        else begin
            failCount++;
            $error("rvalid dropped or read data changed before rready");
        end

    noWriteWhilePending: assert property (@(posedge clk) disable iff (reset)
        axiRsp.bvalid |-> !axiRsp.awready && !axiRsp.wready)
        else begin
            failCount++;
            $error("write accepted while a write response was pending");
        end

    noReadWhilePending: assert property (@(posedge clk) disable iff (reset)
        axiRsp.rvalid |-> !axiRsp.arready)
        else begin
            failCount++;
            $error("read accepted while a read response was pending");
        end

    quietAfterReset: assert property (@(posedge clk)
        reset |=> !axiRsp.awready && !axiRsp.wready && !axiRsp.bvalid
                  && !axiRsp.arready && !axiRsp.rvalid)
        else begin
            failCount++;
            $error("handshake output high in the cycle after reset");
        end

endmodule

bind aluRegSlave aluCore_props i_aluCoreProps (
    .clk    (clk),
    .reset  (reset),
    .axiReq (axiReq),
    .axiRsp (axiRsp)
);

// File: sim/aluCore_tb.sv
// Testbench for the ALU coprocessor with AXI4-Lite driver tasks, reference model and watchdog
`timescale 1ns/10ps

module aluCore_tb;

    localparam int clkPeriod      = 100;
    localparam int resetCycles    = 5;
    localparam int shiftOps       = 128;         // 16 amounts, 4 kinds, two forms
    localparam int randomOps      = 200;
    localparam int cyclesPerOp    = 60;          // Five transfers with back-pressure
    localparam int watchdogCycles = (shiftOps + randomOps + 20) * cyclesPerOp + resetCycles;

    logic                            clk = 1'b0;
    logic                            reset;
    axiLitePkg::axiLiteReq           axiReq;
    axiLitePkg::axiLiteRsp           axiRsp;
    logic [31:0]                     seed = 32'd89562;
    logic [2:0]                      otherGroups [4] = '{aluPkg::opNop, aluPkg::opJump,
                                                         aluPkg::opBranch, aluPkg::opMem};
    logic [axiLitePkg::addrWidth-1:0] badWrite [4] = '{5'h0C, 5'h10, 5'h14, 5'h1C};
    logic [axiLitePkg::addrWidth-1:0] badRead [4]  = '{5'h14, 5'h18, 5'h1C, 5'h02};

    aluCore i_aluCore (
        .clk    (clk),
        .reset  (reset),
        .axiReq (axiReq),
        .axiRsp (axiRsp)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [15:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];                      // High bits have the longest period
    endfunction

    // Expected {carry, result} straight from the instruction rules
    function automatic logic [16:0] refModel(input aluPkg::aluCtrl cw, input logic [15:0] a,
                                             input logic [15:0] b);
        logic [16:0] addSum;
        logic [16:0] subSum;
        logic [31:0] rotL;
        logic [31:0] rotR;
        logic [1:0]  fn;
        logic [16:0] arith;
        logic [15:0] shift;
        addSum = {1'b0, a} + {1'b0, b};
        subSum = {a >= b, a - b};                // Carry means no borrow
        rotL   = {a, a} << b[3:0];
        rotR   = {a, a} >> b[3:0];
        fn     = (cw.opcode[4:2] == aluPkg::opRegOp) ? cw.funct : cw.opcode[1:0];
        case (fn)
            aluPkg::fnAdd: arith = addSum;
            aluPkg::fnSub: arith = subSum;
            aluPkg::fnXor: arith = {1'b0, a ^ b};
            default:       arith = {1'b0, ~(a & b)};
        endcase
        case (fn)
            aluPkg::fnSll: shift = a << b[3:0];
            aluPkg::fnSrl: shift = a >> b[3:0];
            aluPkg::fnRol: shift = rotL[31:16];
            default:       shift = rotR[15:0];
        endcase
        case (cw.opcode[4:2])
            aluPkg::opArithImm: return arith;
            aluPkg::opShiftImm: return {1'b0, shift};
            aluPkg::opRegOp: begin
                if (cw.opcode[1:0] == aluPkg::subRegArith) return arith;
                if (cw.opcode[1:0] == aluPkg::subRegShift) return {1'b0, shift};
                return '0;
            end
            aluPkg::opCond: begin
                case (cw.opcode[1:0])
                    2'b00:   return 17'(a == b);
                    2'b01:   return 17'($signed(a) < $signed(b));
                    2'b10:   return 17'($signed(a) <= $signed(b));
                    default: return 17'(addSum[16]);  // SCO
                endcase
            end
            default: return '0;                  // Jump, branch, memory, NOP
        endcase
    endfunction

    task automatic checkEqual(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic axiWrite(input logic [axiLitePkg::addrWidth-1:0] addr,
                            input logic [15:0] data, output logic [1:0] resp);
        int delay;
        delay = nextRand() % 4;
        axiReq.awvalid <= 1'b1;
        axiReq.wvalid  <= 1'b1;
        axiReq.awaddr  <= addr;
        axiReq.wdata   <= 32'(data);
        axiReq.wstrb   <= 4'hF;
        do @(posedge clk); while (!(axiRsp.awready && axiRsp.wready));
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid  <= 1'b0;
        do @(posedge clk); while (!axiRsp.bvalid);
        axiReq.awvalid <= 1'b1;                  // Second write offered while bready is low
        axiReq.wvalid  <= 1'b1;
        axiReq.wdata   <= 32'(~data);
        repeat (delay) @(posedge clk);
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid  <= 1'b0;
        axiReq.bready  <= 1'b1;
        @(posedge clk);
        resp = axiRsp.bresp;
        axiReq.bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [axiLitePkg::addrWidth-1:0] addr,
                           output logic [31:0] data, output logic [1:0] resp);
        int delay;
        delay = nextRand() % 4;
        axiReq.arvalid <= 1'b1;
        axiReq.araddr  <= addr;
        do @(posedge clk); while (!axiRsp.arready);
        axiReq.arvalid <= 1'b0;
        do @(posedge clk); while (!axiRsp.rvalid);
        axiReq.arvalid <= 1'b1;                  // Second read offered while rready is low
        axiReq.araddr  <= ~addr;
        repeat (delay) @(posedge clk);
        axiReq.arvalid <= 1'b0;
        axiReq.rready  <= 1'b1;
        @(posedge clk);
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        axiReq.rready <= 1'b0;
    endtask

    task automatic runOp(input aluPkg::aluCtrl cw, input logic [15:0] a, input logic [15:0] b);
        logic [31:0] data;
        logic [1:0]  resp;
        logic [16:0] expected;
        string       opText;
        expected = refModel(cw, a, b);
        opText   = $sformatf("op %02h funct %0d a %04h b %04h", cw.opcode, cw.funct, a, b);
        axiWrite(axiLitePkg::regA, a, resp);
        checkEqual({opText, " regA bresp"}, 32'(axiLitePkg::respOkay), 32'(resp));
        axiWrite(axiLitePkg::regB, b, resp);
        checkEqual({opText, " regB bresp"}, 32'(axiLitePkg::respOkay), 32'(resp));
        axiWrite(axiLitePkg::regCtrl, 16'(cw), resp);
        checkEqual({opText, " bresp"}, 32'(axiLitePkg::respOkay), 32'(resp));
        axiRead(axiLitePkg::regResult, data, resp);
        checkEqual({opText, " result"}, 32'(expected[15:0]), data);
        axiRead(axiLitePkg::regStatus, data, resp);
        checkEqual({opText, " carry"}, 32'(expected[16]), data);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("simulation timed out");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    // Bound handshake assertions count their failures
    always @(negedge clk) begin
        if (i_aluCore.i_aluRegSlave.i_aluCoreProps.failCount != 0) begin
            $display("AXI4-Lite handshake rule broken in the register slave at %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "handshake assertion failed");
        end
    end

    initial begin
        aluPkg::aluCtrl cw;
        logic [31:0]    data;
        logic [1:0]     resp;
        logic [15:0]    a;
        logic [15:0]    b;
        axiReq = '0;
        reset  = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Zero registers decode as NOP
        axiRead(axiLitePkg::regResult, data, resp);
        checkEqual("reset result", 32'h0, data);
        checkEqual("reset rresp", 32'(axiLitePkg::respOkay), 32'(resp));
        axiRead(axiLitePkg::regStatus, data, resp);
        checkEqual("reset carry", 32'h0, data);

        for (int amt = 0; amt < 16; amt++) begin
            for (int k = 0; k < 4; k++) begin
                a         = nextRand();
                b         = (nextRand() & 16'hFFF0) | 16'(amt);
                cw.opcode = {aluPkg::opShiftImm, 2'(k)};
                cw.funct  = 2'(nextRand());      // Not used by immediate shifts
                runOp(cw, a, b);
                cw.opcode = {aluPkg::opRegOp, aluPkg::subRegShift};
                cw.funct  = 2'(k);
                runOp(cw, a, b);
            end
        end

        for (int i = 0; i < randomOps; i++) begin
            a = nextRand();
            b = nextRand();
            case (nextRand() % 8)
                0: b = a;
                1: a = 16'h8000;
                2: b = 16'h7FFF;
                3: begin
                    a = 16'h7FFF;
                    b = 16'h8000;
                end
                default: ;
            endcase
            cw.funct = 2'(nextRand());
            case (nextRand() % 4)
                0: cw.opcode = {aluPkg::opArithImm, 2'(nextRand())};
                1: cw.opcode = {aluPkg::opRegOp, aluPkg::subRegArith};
                2: cw.opcode = {aluPkg::opCond, 2'(nextRand())};
                default: cw.opcode = {otherGroups[nextRand() % 4], 2'(nextRand())};
            endcase
            runOp(cw, a, b);
        end

        // Unmapped offsets must leave the host registers alone
        cw.opcode = {aluPkg::opRegOp, aluPkg::subRegArith};
        cw.funct  = aluPkg::fnXor;
        axiWrite(axiLitePkg::regA, 16'h1234, resp);
        axiWrite(axiLitePkg::regB, 16'hABCD, resp);
        axiWrite(axiLitePkg::regCtrl, 16'(cw), resp);
        for (int i = 0; i < 4; i++) begin
            axiWrite(badWrite[i], 16'hFFFF, resp);
            checkEqual("unmapped bresp", 32'(axiLitePkg::respSlvErr), 32'(resp));
            axiRead(badRead[i], data, resp);
            checkEqual("unmapped rdata", 32'h0, data);
            checkEqual("unmapped rresp", 32'(axiLitePkg::respSlvErr), 32'(resp));
        end
        axiRead(axiLitePkg::regA, data, resp);
        checkEqual("regA readback", 32'h1234, data);
        axiRead(axiLitePkg::regB, data, resp);
        checkEqual("regB readback", 32'hABCD, data);
        axiRead(axiLitePkg::regCtrl, data, resp);
        checkEqual("regCtrl readback", 32'(cw), data);

        repeat (2) @(posedge clk);               // Last bound checks complete
        $display("TEST OK");
        $finish;
    end

endmodule

// File: aluCore.f
src/aluPkg.sv
src/axiLitePkg.sv
src/claAdder.sv
src/barrelShifter.sv
src/alu.sv
src/aluRegSlave.sv
src/aluCore.sv
sim/aluCore_props.sv
sim/aluCore_tb.sv

// File: run.sh
#!/bin/sh
# Build the ALU coprocessor testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module aluCore_tb -f aluCore.f -Mdir obj_dir -o simAluCore \
    && ./obj_dir/simAluCore \
    || { echo "simulation did not pass"; exit 1; }
